// ==== dv/gat_core_sva.sv ====
/*
 * Credit and valid checks bound into gat_core.
 * Output credits are tracked here from out_valid and out_credit.
 * fail_count counts failed assertions for the testbench to read.
 */
`default_nettype none

module gat_core_sva #(
  parameter int  FEAT_IN     = gat_pkg::FEAT_IN_DEF,
  parameter int  FEAT_OUT    = gat_pkg::FEAT_OUT_DEF,
  parameter int  OUT_CREDITS = gat_pkg::OUT_CREDITS_DEF,
  localparam int WH_W        = gat_pkg::wh_width(FEAT_IN),
  localparam int SC_W        = gat_pkg::score_width(WH_W, FEAT_OUT),
  localparam int COEF_W      = SC_W + 1
) (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          in_credit,
  input logic                          out_valid,
  input logic                          out_credit,
  input logic [FEAT_OUT-1:0][WH_W-1:0] out_wh,
  input logic signed [SC_W-1:0]        out_src,
  input logic signed [SC_W-1:0]        out_dst,
  input logic signed [COEF_W-1:0]      out_coef
);

  localparam int OC_W = $clog2(OUT_CREDITS + 1);

  logic [OC_W-1:0] credits;
  logic            rst_seen = 1'b0;
  int              fail_count = 0;

  always @(posedge clk) begin
    rst_seen <= !rst_n;
    if (!rst_n) begin
      credits <= OC_W'(OUT_CREDITS);
    end else begin
      credits <= credits - OC_W'(out_valid) + OC_W'(out_credit);
    end
  end

  // First reset edge clears the registers, checked from the second on
  quiet_in_reset: assert property (@(posedge clk)
    (!rst_n && rst_seen) |-> (!out_valid && !in_credit))
    else begin
      $error("out_valid or in_credit active during reset");
      fail_count++;
    end

  valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (credits != '0))
    else begin
      $error("out_valid with no output credit left");
      fail_count++;
    end

  known_when_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown({out_wh, out_src, out_dst, out_coef}))
    else begin
      $error("unknown result bits while out_valid");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/gat_core_tb.sv ====
/*
 * Testbench for gat_core with the package default sizes.
 * Stimulus is driven on the falling edge, outputs sampled there too.
 * Weights are only rewritten after the pipeline has drained.
 */
`default_nettype none

module gat_core_tb;

  import gat_pkg::*;

  localparam int FEAT_IN     = FEAT_IN_DEF;
  localparam int FEAT_OUT    = FEAT_OUT_DEF;
  localparam int IN_DEPTH    = IN_DEPTH_DEF;
  localparam int MID_DEPTH   = MID_DEPTH_DEF;
  localparam int OUT_CREDITS = OUT_CREDITS_DEF;
  localparam int WH_W        = wh_width(FEAT_IN);
  localparam int SC_W        = score_width(WH_W, FEAT_OUT);
  localparam int COEF_W      = SC_W + 1;
  localparam int W_SIZE      = FEAT_OUT * FEAT_IN;
  localparam int A_SIZE      = 2 * FEAT_OUT;
  localparam int WGT_ADDR_W  = $clog2(W_SIZE + A_SIZE);
  localparam int PERIOD      = 40;
  localparam int RAND_NODES  = 50;
  localparam int HOLD_NODES  = 12;
  localparam int NODES       = 1 + RAND_NODES + HOLD_NODES + 1;
  localparam int TIMEOUT     = NODES * (FEAT_OUT + 10) * PERIOD + 1000 * PERIOD;

  typedef elem_t [FEAT_IN-1:0]           feat_vec_t;
  typedef logic [FEAT_OUT-1:0][WH_W-1:0] wh_vec_t;

  typedef struct packed {
    wh_vec_t                  wh;
    logic signed [SC_W-1:0]   src;
    logic signed [SC_W-1:0]   dst;
    logic signed [COEF_W-1:0] coef;
  } result_t;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     in_valid;
  feat_vec_t                in_feat;
  logic                     in_credit;
  logic                     wgt_we;
  logic [WGT_ADDR_W-1:0]    wgt_addr;
  elem_t                    wgt_din;
  logic                     out_valid;
  wh_vec_t                  out_wh;
  logic signed [SC_W-1:0]   out_src;
  logic signed [SC_W-1:0]   out_dst;
  logic signed [COEF_W-1:0] out_coef;
  logic                     out_credit;

  int                       w_ref [W_SIZE];
  int                       a_ref [A_SIZE];
  result_t                  exp_q [$];
  logic [15:0]              lfsr = 16'd25;
  int                       in_cred;
  int                       pending = 0;
  int                       out_count = 0;
  int                       nodes_sent = 0;
  int                       credit_pulses = 0;
  logic                     hold_out = 1'b0;
  wh_vec_t                  last_wh;
  logic signed [SC_W-1:0]   last_src;
  logic signed [SC_W-1:0]   last_dst;
  logic signed [COEF_W-1:0] last_coef;

  gat_core #(
    .FEAT_IN     (FEAT_IN),
    .FEAT_OUT    (FEAT_OUT),
    .IN_DEPTH    (IN_DEPTH),
    .MID_DEPTH   (MID_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) gat_core_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_feat    (in_feat),
    .in_credit  (in_credit),
    .wgt_we     (wgt_we),
    .wgt_addr   (wgt_addr),
    .wgt_din    (wgt_din),
    .out_valid  (out_valid),
    .out_wh     (out_wh),
    .out_src    (out_src),
    .out_dst    (out_dst),
    .out_coef   (out_coef),
    .out_credit (out_credit)
  );

  bind gat_core gat_core_sva #(
    .FEAT_IN     (FEAT_IN),
    .FEAT_OUT    (FEAT_OUT),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .out_wh     (out_wh),
    .out_src    (out_src),
    .out_dst    (out_dst),
    .out_coef   (out_coef)
  );

  always #(PERIOD / 2) clk = ~clk;

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_feat(output feat_vec_t f);
    logic [31:0] v;
    for (int i = 0; i < FEAT_IN; i++) begin
      rand_bits(8, v);
      f[i] = v[7:0];
    end
  endtask

  // Expected Wh, scores and coefficient from the current weights
  function automatic result_t ref_result(input feat_vec_t f);
    result_t r;
    int      wh_i;
    int      src;
    int      dst;
    int      sum;
    src = 0;
    dst = 0;
    for (int j = 0; j < FEAT_OUT; j++) begin
      wh_i = 0;
      for (int i = 0; i < FEAT_IN; i++) begin
        wh_i = wh_i + int'(f[i]) * w_ref[j * FEAT_IN + i];
      end
      r.wh[j] = WH_W'(wh_i);
      src     = src + wh_i * a_ref[j];
      dst     = dst + wh_i * a_ref[FEAT_OUT + j];
    end
    sum    = src + dst;
    r.src  = SC_W'(src);
    r.dst  = SC_W'(dst);
    r.coef = COEF_W'((sum < 0) ? (sum >>> LEAKY_SHIFT) : sum);
    return r;
  endfunction

  task automatic write_weight(input int addr, input int val);
    elem_t e;
    e        = elem_t'(val);
    wgt_we   = 1'b1;
    wgt_addr = WGT_ADDR_W'(addr);
    wgt_din  = e;
    if (addr < W_SIZE) begin
      w_ref[addr] = int'(e);
    end else begin
      a_ref[addr - W_SIZE] = int'(e);
    end
    @(negedge clk);
    wgt_we = 1'b0;
  endtask

  task automatic load_identity(input int a_src, input int a_dst);
    for (int j = 0; j < FEAT_OUT; j++) begin
      for (int i = 0; i < FEAT_IN; i++) begin
        write_weight(j * FEAT_IN + i, (i == j) ? 1 : 0);
      end
    end
    for (int j = 0; j < FEAT_OUT; j++) begin
      write_weight(W_SIZE + j, a_src);
      write_weight(W_SIZE + FEAT_OUT + j, a_dst);
    end
  endtask

  task automatic load_random_weights();
    logic [31:0] v;
    for (int addr = 0; addr < W_SIZE + A_SIZE; addr++) begin
      rand_bits(8, v);
      write_weight(addr, int'(v[7:0]));
    end
  endtask

  task automatic send_node(input feat_vec_t f);
    while (in_cred == 0) begin
      @(negedge clk);
    end
    in_valid = 1'b1;
    in_feat  = f;
    in_cred--;
    exp_q.push_back(ref_result(f));
    nodes_sent++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Every result seen and every output credit handed back
  task automatic drain();
    while (exp_q.size() != 0 || pending != 0) begin
      @(negedge clk);
    end
  endtask

  // ==========================================================
  // Credit counting, compare and sink
  // ==========================================================
  always @(posedge clk) begin
    if (rst_n && in_credit === 1'b1) begin
      in_cred++;
      credit_pulses++;
    end
  end

  always @(negedge clk) begin
    result_t e;
    if (rst_n && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_run("out_valid seen with no node outstanding");
      end else begin
        e = exp_q.pop_front();
        for (int j = 0; j < FEAT_OUT; j++) begin
          check($sformatf("out_wh[%0d]", j), out_wh[j], e.wh[j]);
        end
        check("out_src", out_src, e.src);
        check("out_dst", out_dst, e.dst);
        check("out_coef", out_coef, e.coef);
        last_wh   = out_wh;
        last_src  = out_src;
        last_dst  = out_dst;
        last_coef = out_coef;
        out_count++;
        pending++;
      end
    end
    if (!hold_out && pending > 0) begin
      out_credit = 1'b1;
      pending--;
    end else begin
      out_credit = 1'b0;
    end
  end

  initial begin
    #(TIMEOUT);
    stop_run("watchdog expired before the tests finished");
  end

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    feat_vec_t                f;
    int                       sc;
    int                       base;
    logic [WH_W-1:0]          exp_wh;
    logic signed [SC_W-1:0]   exp_sc;
    logic signed [COEF_W-1:0] exp_coef;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_feat    = '0;
    wgt_we     = 1'b0;
    wgt_addr   = '0;
    wgt_din    = '0;
    out_credit = 1'b0;
    in_cred    = IN_DEPTH;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Quiet outputs before any input
    repeat (4) begin
      @(negedge clk);
      check("in_credit", in_credit, 1'b0);
      check("out_valid", out_valid, 1'b0);
    end

    // Identity W, a all ones
    load_identity(1, 1);
    rand_feat(f);
    send_node(f);
    drain();
    sc = 0;
    for (int j = 0; j < FEAT_OUT; j++) begin
      exp_wh = WH_W'(int'(f[j]));
      check($sformatf("out_wh[%0d]", j), last_wh[j], exp_wh);
      sc = sc + int'(f[j]);
    end
    exp_sc = SC_W'(sc);
    check("out_src", last_src, exp_sc);
    check("out_dst", last_dst, exp_sc);

    load_random_weights();
    for (int n = 0; n < RAND_NODES; n++) begin
      rand_feat(f);
      send_node(f);
    end
    drain();

    // Output credits withheld while the pipeline fills
    hold_out = 1'b1;
    base     = out_count;
    fork
      begin
        for (int n = 0; n < HOLD_NODES; n++) begin
          rand_feat(f);
          send_node(f);
        end
      end
      begin
        repeat (100) @(negedge clk);
        check("results while held", out_count - base, OUT_CREDITS);
        check("input credits while held", in_cred, 0);
        hold_out = 1'b0;
      end
    join
    drain();

    // Negative sum, a src half -1 and dst half -2
    load_identity(-1, -2);
    for (int i = 0; i < FEAT_IN; i++) begin
      f[i] = elem_t'(5);
    end
    send_node(f);
    drain();
    sc       = -5 * FEAT_OUT;
    exp_coef = COEF_W'((sc + 2 * sc) >>> LEAKY_SHIFT);
    check("out_coef", last_coef, exp_coef);

    check("in_credit pulses", credit_pulses, nodes_sent);

    if (gat_core_i.u_sva.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d assertion failures in the bound checker",
                         gat_core_i.u_sva.fail_count));
    end
  end

endmodule

`default_nettype wire

// ==== gat_core.f ====
src/gat_pkg.sv
src/credit_fifo.sv
src/wh_proj.sv
src/attn_score.sv
src/gat_core.sv
dv/gat_core_sva.sv
dv/gat_core_tb.sv

// ==== src/attn_score.sv ====
/*
 * Attention scoring, two pipeline stages from pop to out_valid.
 * Entries 0..FEAT_OUT-1 of a give the source score, the rest the
 * destination score. a must not change while a node is in flight.
 * Output credits are charged at pop, so in-flight items hold one.
 */
`default_nettype none

module attn_score #(
  parameter int  FEAT_IN     = gat_pkg::FEAT_IN_DEF,
  parameter int  FEAT_OUT    = gat_pkg::FEAT_OUT_DEF,
  parameter int  OUT_CREDITS = gat_pkg::OUT_CREDITS_DEF,
  localparam int WH_W        = gat_pkg::wh_width(FEAT_IN),
  localparam int SC_W        = gat_pkg::score_width(WH_W, FEAT_OUT),
  localparam int COEF_W      = SC_W + 1,
  localparam int A_ADDR_W    = $clog2(2 * FEAT_OUT)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          a_we,
  input  logic [A_ADDR_W-1:0]           a_addr,
  input  gat_pkg::elem_t                a_din,
  input  logic [FEAT_OUT-1:0][WH_W-1:0] wh,
  input  logic                          wh_ready,
  output logic                          wh_pop,
  output logic                          out_valid,
  output logic [FEAT_OUT-1:0][WH_W-1:0] out_wh,
  output logic signed [SC_W-1:0]        out_src,
  output logic signed [SC_W-1:0]        out_dst,
  output logic signed [COEF_W-1:0]      out_coef,
  input  logic                          out_credit
);

  import gat_pkg::*;

  localparam int OC_W = $clog2(OUT_CREDITS + 1);

  elem_t                         a_mem [2 * FEAT_OUT];
  logic signed [SC_W-1:0]        src;
  logic signed [SC_W-1:0]        dst;
  logic                          s1_valid;
  logic [FEAT_OUT-1:0][WH_W-1:0] s1_wh;
  logic signed [SC_W-1:0]        s1_src;
  logic signed [SC_W-1:0]        s1_dst;
  logic signed [COEF_W-1:0]      sum;
  logic [OC_W-1:0]               cred;

  always_ff @(posedge clk) begin
    if (a_we) begin
      a_mem[a_addr] <= a_din;
    end
  end

  always_comb begin
    src = '0;
    dst = '0;
    for (int j = 0; j < FEAT_OUT; j++) begin
      src = src + $signed(wh[j]) * a_mem[j];
      dst = dst + $signed(wh[j]) * a_mem[FEAT_OUT + j];
    end
  end

  assign wh_pop = wh_ready && (cred != '0);
  assign sum    = s1_src + s1_dst;

  // ==========================================================
  // Stage 1 scores, stage 2 leaky ReLU
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= wh_pop;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_wh    <= wh;
    s1_src   <= src;
    s1_dst   <= dst;
    out_wh   <= s1_wh;
    out_src  <= s1_src;
    out_dst  <= s1_dst;
    out_coef <= sum[COEF_W-1] ? (sum >>> LEAKY_SHIFT) : sum;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cred <= OC_W'(OUT_CREDITS);
    end else begin
      cred <= cred - OC_W'(wh_pop) + OC_W'(out_credit);
    end
  end

endmodule

`default_nettype wire

// ==== src/credit_fifo.sv ====
/*
 * Circular buffer with one credit pulse per pop.
 * The writer must hold a credit before each push, so no full flag
 * exists and a push into a full buffer is not guarded.
 * Head data is combinational, valid while not_empty is high.
 */
`default_nettype none

module credit_fifo #(
  parameter type payload_t = gat_pkg::elem_t,
  parameter int  DEPTH     = gat_pkg::IN_DEPTH_DEF
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  assign pop_data  = mem[rd_ptr];
  // Slot is free as soon as the head leaves
  assign credit    = do_pop;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/gat_core.sv ====
/*
 * One attention layer front end: projection, then scoring.
 * Credit flow on both sides, initial credits IN_DEPTH and OUT_CREDITS.
 * Weight load only while no node is in flight. W first, then a with
 * the source half first. Writes past the a range are dropped.
 */
`default_nettype none

module gat_core #(
  parameter int  FEAT_IN     = gat_pkg::FEAT_IN_DEF,
  parameter int  FEAT_OUT    = gat_pkg::FEAT_OUT_DEF,
  parameter int  IN_DEPTH    = gat_pkg::IN_DEPTH_DEF,
  parameter int  MID_DEPTH   = gat_pkg::MID_DEPTH_DEF,
  parameter int  OUT_CREDITS = gat_pkg::OUT_CREDITS_DEF,
  localparam int WH_W        = gat_pkg::wh_width(FEAT_IN),
  localparam int SC_W        = gat_pkg::score_width(WH_W, FEAT_OUT),
  localparam int COEF_W      = SC_W + 1,
  localparam int WGT_ADDR_W  = $clog2(FEAT_OUT * FEAT_IN + 2 * FEAT_OUT)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  gat_pkg::elem_t [FEAT_IN-1:0]  in_feat,
  output logic                          in_credit,
  input  logic                          wgt_we,
  input  logic [WGT_ADDR_W-1:0]         wgt_addr,
  input  gat_pkg::elem_t                wgt_din,
  output logic                          out_valid,
  output logic [FEAT_OUT-1:0][WH_W-1:0] out_wh,
  output logic signed [SC_W-1:0]        out_src,
  output logic signed [SC_W-1:0]        out_dst,
  output logic signed [COEF_W-1:0]      out_coef,
  input  logic                          out_credit
);

  import gat_pkg::*;

  localparam int W_SIZE   = FEAT_OUT * FEAT_IN;
  localparam int A_SIZE   = 2 * FEAT_OUT;
  localparam int W_ADDR_W = $clog2(W_SIZE);
  localparam int A_ADDR_W = $clog2(A_SIZE);

  typedef elem_t [FEAT_IN-1:0]           feat_vec_t;
  typedef logic [FEAT_OUT-1:0][WH_W-1:0] wh_vec_t;

  feat_vec_t               fifo_feat;
  logic                    feat_ready;
  logic                    feat_pop;
  wh_vec_t                 proj_wh;
  wh_vec_t                 mid_wh;
  logic                    proj_valid;
  logic                    mid_credit;
  logic                    mid_ready;
  logic                    mid_pop;
  logic                    w_we;
  logic                    a_we;
  logic [WGT_ADDR_W-1:0]   a_offset;

  // ==========================================================
  // Weight load decode, a range rebased to zero
  // ==========================================================
  assign w_we     = wgt_we && (wgt_addr < W_SIZE);
  assign a_we     = wgt_we && (wgt_addr >= W_SIZE) && (wgt_addr < W_SIZE + A_SIZE);
  assign a_offset = wgt_addr - WGT_ADDR_W'(W_SIZE);

  credit_fifo #(
    .payload_t (feat_vec_t),
    .DEPTH     (IN_DEPTH)
  ) u_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (in_valid),
    .push_data (in_feat),
    .pop       (feat_pop),
    .pop_data  (fifo_feat),
    .not_empty (feat_ready),
    .credit    (in_credit)
  );

  credit_fifo #(
    .payload_t (wh_vec_t),
    .DEPTH     (MID_DEPTH)
  ) u_mid_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (proj_valid),
    .push_data (proj_wh),
    .pop       (mid_pop),
    .pop_data  (mid_wh),
    .not_empty (mid_ready),
    .credit    (mid_credit)
  );

  wh_proj #(
    .FEAT_IN   (FEAT_IN),
    .FEAT_OUT  (FEAT_OUT),
    .MID_DEPTH (MID_DEPTH)
  ) u_wh_proj (
    .clk        (clk),
    .rst_n      (rst_n),
    .w_we       (w_we),
    .w_addr     (W_ADDR_W'(wgt_addr)),
    .w_din      (wgt_din),
    .feat       (fifo_feat),
    .feat_ready (feat_ready),
    .feat_pop   (feat_pop),
    .wh_valid   (proj_valid),
    .wh         (proj_wh),
    .wh_credit  (mid_credit)
  );

  attn_score #(
    .FEAT_IN     (FEAT_IN),
    .FEAT_OUT    (FEAT_OUT),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_attn_score (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_we       (a_we),
    .a_addr     (A_ADDR_W'(a_offset)),
    .a_din      (wgt_din),
    .wh         (mid_wh),
    .wh_ready   (mid_ready),
    .wh_pop     (mid_pop),
    .out_valid  (out_valid),
    .out_wh     (out_wh),
    .out_src    (out_src),
    .out_dst    (out_dst),
    .out_coef   (out_coef),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

// ==== src/gat_pkg.sv ====
/*
 * Shared widths and defaults for the attention front end.
 * Elements are signed int8. Wh and score widths are full precision,
 * so no stage saturates or rounds.
 */
`default_nettype none

package gat_pkg;

  // Element width of features, weights and attention entries
  localparam int DATA_W = 8;

  typedef logic signed [DATA_W-1:0] elem_t;

  // Right shift applied to negative coefficients
  localparam int LEAKY_SHIFT = 3;

  // ==========================================================
  // Default sizes
  // ==========================================================
  localparam int FEAT_IN_DEF     = 8;
  localparam int FEAT_OUT_DEF    = 4;
  localparam int IN_DEPTH_DEF    = 4;
  localparam int MID_DEPTH_DEF   = 2;
  localparam int OUT_CREDITS_DEF = 4;

  // One Wh element, sum of n_in products of two elements
  function automatic int wh_width(int n_in);
    return 2 * DATA_W + $clog2(n_in);
  endfunction

  // One score, sum of n_out products of Wh and an attention entry
  function automatic int score_width(int wh_w, int n_out);
    return wh_w + DATA_W + $clog2(n_out);
  endfunction

endpackage

`default_nettype wire

// ==== src/wh_proj.sv ====
/*
 * Projection stage, Wh = W * h, one output column per cycle.
 * W is loaded row-major by output column, then input index, and must
 * not change while a node is in flight.
 * Result is held until a credit toward the mid FIFO is available.
 */
`default_nettype none

module wh_proj #(
  parameter int  FEAT_IN   = gat_pkg::FEAT_IN_DEF,
  parameter int  FEAT_OUT  = gat_pkg::FEAT_OUT_DEF,
  parameter int  MID_DEPTH = gat_pkg::MID_DEPTH_DEF,
  localparam int WH_W      = gat_pkg::wh_width(FEAT_IN),
  localparam int W_ADDR_W  = $clog2(FEAT_OUT * FEAT_IN)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          w_we,
  input  logic [W_ADDR_W-1:0]           w_addr,
  input  gat_pkg::elem_t                w_din,
  input  gat_pkg::elem_t [FEAT_IN-1:0]  feat,
  input  logic                          feat_ready,
  output logic                          feat_pop,
  output logic                          wh_valid,
  output logic [FEAT_OUT-1:0][WH_W-1:0] wh,
  input  logic                          wh_credit
);

  import gat_pkg::*;

  localparam int COL_W = (FEAT_OUT > 1) ? $clog2(FEAT_OUT) : 1;
  localparam int CR_W  = $clog2(MID_DEPTH + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_CALC, ST_PUSH} state_t;

  elem_t                         w_mem [FEAT_OUT * FEAT_IN];
  elem_t [FEAT_IN-1:0]           feat_q;
  logic [FEAT_OUT-1:0][WH_W-1:0] wh_q;
  logic signed [WH_W-1:0]        acc;
  logic [COL_W-1:0]              col;
  logic [CR_W-1:0]               cred;
  state_t                        state;

  always_ff @(posedge clk) begin
    if (w_we) begin
      w_mem[w_addr] <= w_din;
    end
  end

  // ==========================================================
  // Dot product of the latched node with column col
  // ==========================================================
  always_comb begin
    acc = '0;
    for (int i = 0; i < FEAT_IN; i++) begin
      acc = acc + feat_q[i] * w_mem[int'(col) * FEAT_IN + i];
    end
  end

  assign feat_pop = (state == ST_IDLE) && feat_ready;
  assign wh_valid = (state == ST_PUSH) && (cred != '0);
  assign wh       = wh_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      col   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (feat_pop) begin
            state <= ST_CALC;
            col   <= '0;
          end
        end
        ST_CALC: begin
          if (col == COL_W'(FEAT_OUT - 1)) begin
            state <= ST_PUSH;
          end else begin
            col <= col + 1'b1;
          end
        end
        // Stall here without a credit
        ST_PUSH: begin
          if (wh_valid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (feat_pop) begin
      feat_q <= feat;
    end
    if (state == ST_CALC) begin
      wh_q[col] <= acc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cred <= CR_W'(MID_DEPTH);
    end else begin
      cred <= cred - CR_W'(wh_valid) + CR_W'(wh_credit);
    end
  end

endmodule

`default_nettype wire
